/* list.f */
+incdir+include
design/cdw_pkg.sv
design/cdw_trigger.sv
design/cdw_walker.sv
design/dc_checker.sv
design/cdw_top.sv
tests/ddt_mem_model.sv
tests/cdw_tb.sv

/* tests/cdw_tb.sv */
/*
 * Testbench for the device-context walker. Builds directory tables in
 * the memory model, runs walks in each mode and with each kind of fault,
 * and checks reads, update and error pulses against the walk rules.
 */
`timescale 1ns/1ps
`include "cdw_consts.svh"

module cdw_tb;
    import cdw_pkg::*;

    localparam int WALK_TIMEOUT = 300;
    localparam logic [`CDW_PPN_W-1:0] DDT_PPN = 44'h000_0012_3450;
    localparam logic [`CDW_PPN_W-1:0] PPN_A   = 44'h000_0078_9000;
    localparam logic [`CDW_PPN_W-1:0] PPN_B   = 44'h000_0056_7000;
    // fsc, ta, iohgatp, tc
    localparam dc_base_t GOOD_DC = {64'h8000_0000_0456_7000, 64'h0000_0000_1234_5000,
                                    64'h8001_2000_0abc_d000, 64'h0000_0000_0000_0007};

    logic                  clk_i;
    logic                  rst_ni;
    logic                  init;
    logic [`CDW_DID_W-1:0] req_did;
    logic [`CDW_PPN_W-1:0] ddtp_ppn;
    logic [3:0]            ddtp_mode;
    logic                  caps_ats;
    logic                  caps_sv39x4;
    logic                  caps_sv39;
    logic                  caps_pd8;
    logic                  ar_valid;
    logic [`CDW_PLEN-1:0]  ar_addr;
    logic [7:0]            ar_len;
    logic                  ar_ready;
    logic                  r_valid;
    logic [`CDW_DW_W-1:0]  r_data;
    logic [1:0]            r_resp;
    logic                  r_last;
    logic                  r_ready;
    logic                  update_dc;
    logic [`CDW_DID_W-1:0] up_did;
    dc_base_t              up_dc;
    logic                  cdw_error;
    cause_t                cause;
    logic                  active;

    // Filled by the monitor during a walk
    logic [`CDW_PLEN-1:0]  ar_addr_log[$];
    logic [7:0]            ar_len_log[$];
    int                    upd_cnt;
    int                    err_cnt;
    int                    beat_cnt;
    logic                  prev_last;
    logic [`CDW_DID_W-1:0] got_did;
    dc_base_t              got_dc;
    cause_t                got_cause;

    cdw_top u_cdw_top (
        .clk_i (clk_i), .rst_ni (rst_ni), .init_i (init), .req_did_i (req_did),
        .ddtp_ppn_i (ddtp_ppn), .ddtp_mode_i (ddtp_mode), .caps_ats_i (caps_ats),
        .caps_sv39x4_i (caps_sv39x4), .caps_sv39_i (caps_sv39), .caps_pd8_i (caps_pd8),
        .ar_valid_o (ar_valid), .ar_addr_o (ar_addr), .ar_len_o (ar_len),
        .ar_ready_i (ar_ready), .r_valid_i (r_valid), .r_data_i (r_data),
        .r_resp_i (r_resp), .r_last_i (r_last), .r_ready_o (r_ready),
        .update_dc_o (update_dc), .up_did_o (up_did), .up_dc_o (up_dc),
        .cdw_error_o (cdw_error), .cause_o (cause), .active_o (active)
    );

    ddt_mem_model u_mem (
        .clk_i (clk_i), .ar_valid_i (ar_valid), .ar_addr_i (ar_addr), .ar_len_i (ar_len),
        .ar_ready_o (ar_ready), .r_valid_o (r_valid), .r_data_o (r_data),
        .r_resp_o (r_resp), .r_last_o (r_last), .r_ready_i (r_ready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        assert (got === exp)
            else abort_run($sformatf("error: %s is %0h, expected %0h", name, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    function automatic logic [`CDW_PLEN-1:0] root_addr(input logic [3:0] mode,
                                                       input logic [`CDW_DID_W-1:0] did);
        case (mode)
            `CDW_MODE_3LVL: return {DDT_PPN, 1'b0, did[23:16], 3'b000};
            `CDW_MODE_2LVL: return {DDT_PPN, did[15:7], 3'b000};
            default: return {DDT_PPN, did[6:0], 5'b00000};
        endcase
    endfunction

    function automatic logic [`CDW_PLEN-1:0] mid_addr(input logic [`CDW_PPN_W-1:0] ppn,
                                                      input logic [`CDW_DID_W-1:0] did);
        return {ppn, did[15:7], 3'b000};
    endfunction

    function automatic logic [`CDW_PLEN-1:0] leaf_addr(input logic [`CDW_PPN_W-1:0] ppn,
                                                       input logic [`CDW_DID_W-1:0] did);
        return {ppn, did[6:0], 5'b00000};
    endfunction

    function automatic logic [`CDW_DW_W-1:0] nl_entry(input logic [`CDW_PPN_W-1:0] ppn);
        return {10'b0, ppn, 9'b0, 1'b1};
    endfunction

    task automatic put_context(input logic [`CDW_PLEN-1:0] addr, input dc_base_t dc);
        u_mem.write_dw(addr, dc.tc);
        u_mem.write_dw(addr + 8, dc.iohgatp);
        u_mem.write_dw(addr + 16, dc.ta);
        u_mem.write_dw(addr + 24, dc.fsc);
    endtask

    task automatic start_walk(input logic [`CDW_DID_W-1:0] did, input logic [3:0] mode,
                              input logic ats, input logic sv39);
        ar_addr_log.delete();
        ar_len_log.delete();
        upd_cnt   = 0;
        err_cnt   = 0;
        beat_cnt  = 0;
        prev_last = 1'b0;
        req_did   = did;
        ddtp_ppn  = DDT_PPN;
        ddtp_mode = mode;
        caps_ats  = ats;
        caps_sv39 = sv39;
        init      = 1'b1;
    endtask

    // Wait for the result, then keep init high so a repeated start would show
    task automatic finish_walk(input int reads);
        int cycles;
        cycles = 0;
        while (upd_cnt + err_cnt == 0) begin
            next_cycle();
            cycles++;
            if (cycles > WALK_TIMEOUT) begin
                abort_run("walk timed out without an update or error pulse");
            end
        end
        repeat (6) next_cycle();
        check_value("active_o", active, 1'b0);
        check_value("ar handshakes", ar_addr_log.size(), reads);
        init = 1'b0;
        next_cycle();
        u_mem.clear_table();
    endtask

    task automatic expect_fault(input cause_t exp_cause);
        check_value("update_dc_o pulses", upd_cnt, 0);
        check_value("cdw_error_o pulses", err_cnt, 1);
        check_value("cause_o", got_cause, exp_cause);
    endtask

    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (ar_valid && ar_ready) begin
                ar_addr_log.push_back(ar_addr);
                ar_len_log.push_back(ar_len);
            end
            if (update_dc) begin
                upd_cnt++;
                got_did = up_did;
                got_dc  = up_dc;
            end
            if (cdw_error) begin
                err_cnt++;
                got_cause = cause;
                // A fault is only reported once its burst has drained
                assert (prev_last || (r_valid && r_ready && r_last))
                    else abort_run("cdw_error_o pulsed before the read burst ended");
            end
            if (r_valid && r_ready) begin
                beat_cnt++;
                prev_last = r_last;
            end
        end
    end

    a_result_in_walk: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (update_dc || cdw_error) |-> active)
        else abort_run("result pulse outside of a walk");

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    initial begin
        rst_ni      = 1'b0;
        init        = 1'b0;
        req_did     = '0;
        ddtp_ppn    = '0;
        ddtp_mode   = 4'd0;
        caps_ats    = 1'b1;
        caps_sv39x4 = 1'b1;
        caps_sv39   = 1'b1;
        caps_pd8    = 1'b1;
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        next_cycle();

        // Quiet after reset
        check_value("active_o", active, 1'b0);
        check_value("ar_valid_o", ar_valid, 1'b0);
        check_value("r_ready_o", r_ready, 1'b0);
        check_value("update_dc_o", update_dc, 1'b0);
        check_value("cdw_error_o", cdw_error, 1'b0);

        // Single-level walk to a good context
        put_context(root_addr(`CDW_MODE_1LVL, 24'h00_005a), GOOD_DC);
        start_walk(24'h00_005a, `CDW_MODE_1LVL, 1'b1, 1'b1);
        finish_walk(1);
        check_value("ar_addr_o", ar_addr_log[0], root_addr(`CDW_MODE_1LVL, 24'h00_005a));
        check_value("ar_len_o", ar_len_log[0], 8'd3);
        check_value("update_dc_o pulses", upd_cnt, 1);
        check_value("cdw_error_o pulses", err_cnt, 0);
        check_value("up_did_o", got_did, 24'h00_005a);
        check_value("up_dc_o", got_dc, GOOD_DC);

        // Three-level walk
        u_mem.write_dw(root_addr(`CDW_MODE_3LVL, 24'ha5_b37c), nl_entry(PPN_A));
        u_mem.write_dw(mid_addr(PPN_A, 24'ha5_b37c), nl_entry(PPN_B));
        put_context(leaf_addr(PPN_B, 24'ha5_b37c), GOOD_DC);
        start_walk(24'ha5_b37c, `CDW_MODE_3LVL, 1'b1, 1'b1);
        finish_walk(3);
        check_value("ar_addr_o", ar_addr_log[0], root_addr(`CDW_MODE_3LVL, 24'ha5_b37c));
        check_value("ar_addr_o", ar_addr_log[1], mid_addr(PPN_A, 24'ha5_b37c));
        check_value("ar_addr_o", ar_addr_log[2], leaf_addr(PPN_B, 24'ha5_b37c));
        check_value("ar_len_o", {ar_len_log[0], ar_len_log[1], ar_len_log[2]}, 24'h00_0003);
        check_value("update_dc_o pulses", upd_cnt, 1);
        check_value("up_did_o", got_did, 24'ha5_b37c);
        check_value("up_dc_o", got_dc, GOOD_DC);

        // Second-level entry not valid
        u_mem.write_dw(root_addr(`CDW_MODE_3LVL, 24'h3c_4193), nl_entry(PPN_A));
        u_mem.write_dw(mid_addr(PPN_A, 24'h3c_4193), nl_entry(PPN_B) & ~64'h1);
        start_walk(24'h3c_4193, `CDW_MODE_3LVL, 1'b1, 1'b1);
        finish_walk(2);
        expect_fault(`CDW_CAUSE_DDT_INVALID);

        // Reserved bit set in a root entry
        u_mem.write_dw(root_addr(`CDW_MODE_2LVL, 24'h3c_4193), nl_entry(PPN_A) | 64'h8);
        start_walk(24'h3c_4193, `CDW_MODE_2LVL, 1'b1, 1'b1);
        finish_walk(1);
        expect_fault(`CDW_CAUSE_DDT_MISCONF);

        // ATS requested but not supported, flagged on the first beat
        put_context(root_addr(`CDW_MODE_1LVL, 24'h00_0011), GOOD_DC);
        start_walk(24'h00_0011, `CDW_MODE_1LVL, 1'b0, 1'b1);
        finish_walk(1);
        expect_fault(`CDW_CAUSE_DDT_MISCONF);
        check_value("accepted beats", beat_cnt, `CDW_DC_BEATS);

        // tc.v low
        put_context(root_addr(`CDW_MODE_1LVL, 24'h00_0022),
                    {GOOD_DC[255:64], 64'h0000_0000_0000_0006});
        start_walk(24'h00_0022, `CDW_MODE_1LVL, 1'b1, 1'b1);
        finish_walk(1);
        expect_fault(`CDW_CAUSE_DDT_INVALID);

        // fsc in sv39 mode without sv39 support
        put_context(root_addr(`CDW_MODE_1LVL, 24'h00_0033), GOOD_DC);
        start_walk(24'h00_0033, `CDW_MODE_1LVL, 1'b1, 1'b0);
        finish_walk(1);
        expect_fault(`CDW_CAUSE_DDT_MISCONF);

        // Bus error on the ta beat
        put_context(root_addr(`CDW_MODE_1LVL, 24'h00_0044), GOOD_DC);
        u_mem.mark_slverr(root_addr(`CDW_MODE_1LVL, 24'h00_0044) + 16);
        start_walk(24'h00_0044, `CDW_MODE_1LVL, 1'b1, 1'b1);
        finish_walk(1);
        expect_fault(`CDW_CAUSE_DDT_CORRUPT);
        check_value("accepted beats", beat_cnt, `CDW_DC_BEATS);

        $display("test passed");
        $finish;
    end

endmodule

/* tests/ddt_mem_model.sv */
/*
 * Read-only memory for the walker testbench. Answers read bursts from a
 * table of doublewords, with random accept and beat delays, and returns
 * SLVERR for addresses that are marked as faulty.
 */
`timescale 1ns/1ps
`include "cdw_consts.svh"

module ddt_mem_model (
    input  logic                 clk_i,
    input  logic                 ar_valid_i,
    input  logic [`CDW_PLEN-1:0] ar_addr_i,
    input  logic [7:0]           ar_len_i,
    output logic                 ar_ready_o,
    output logic                 r_valid_o,
    output logic [`CDW_DW_W-1:0] r_data_o,
    output logic [1:0]           r_resp_o,
    output logic                 r_last_o,
    input  logic                 r_ready_i
);
    localparam int BEAT_TIMEOUT = 64;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [`CDW_DW_W-1:0] table_q [logic [`CDW_PLEN-1:0]];
    bit                   slverr_q [logic [`CDW_PLEN-1:0]];
    logic [31:0]          rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic write_dw(input logic [`CDW_PLEN-1:0] addr, input logic [`CDW_DW_W-1:0] data);
        table_q[addr] = data;
    endtask

    task automatic mark_slverr(input logic [`CDW_PLEN-1:0] addr);
        slverr_q[addr] = 1'b1;
    endtask

    task automatic clear_table();
        table_q.delete();
        slverr_q.delete();
    endtask

    // Unwritten locations read back a pattern of their own address
    function automatic logic [`CDW_DW_W-1:0] lookup(input logic [`CDW_PLEN-1:0] addr);
        if (table_q.exists(addr)) begin
            return table_q[addr];
        end
        return {addr[7:0], addr};
    endfunction

    // Zero to three idle cycles
    task automatic pause();
        int gap;
        rng = xorshift32(rng);
        gap = int'(rng[1:0]);
        repeat (gap) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic serve_burst();
        logic [`CDW_PLEN-1:0] addr;
        logic [`CDW_PLEN-1:0] beat_addr;
        logic [7:0]           len;
        int                   beat;
        int                   wait_cnt;
        addr = ar_addr_i;
        len  = ar_len_i;
        pause();
        ar_ready_o = 1'b1;
        @(posedge clk_i);
        #1;
        ar_ready_o = 1'b0;
        for (beat = 0; beat <= int'(len); beat++) begin
            pause();
            beat_addr = addr + beat * 8;
            r_valid_o = 1'b1;
            r_data_o  = lookup(beat_addr);
            r_resp_o  = slverr_q.exists(beat_addr) ? RESP_SLVERR : 2'b00;
            r_last_o  = (beat == int'(len));
            // Hold the beat until the walker takes it or the wait runs out
            wait_cnt = 0;
            while (!r_ready_i && wait_cnt < BEAT_TIMEOUT) begin
                @(posedge clk_i);
                #1;
                wait_cnt++;
            end
            @(posedge clk_i);
            #1;
            r_valid_o = 1'b0;
            r_last_o  = 1'b0;
        end
    endtask

    initial begin
        rng        = 32'h7071b0af;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = 2'b00;
        r_last_o   = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            if (ar_valid_i) begin
                serve_burst();
            end
        end
    end

endmodule

/* design/cdw_top.sv */
/*
 * Device-context walker top level. Connects the trigger, the walk
 * state machine and the context checker to the read channel.
 */
`timescale 1ns/1ps
`include "cdw_consts.svh"

module cdw_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  init_i,
    input  logic [`CDW_DID_W-1:0] req_did_i,
    input  logic [`CDW_PPN_W-1:0] ddtp_ppn_i,
    input  logic [3:0]            ddtp_mode_i,
    input  logic                  caps_ats_i,
    input  logic                  caps_sv39x4_i,
    input  logic                  caps_sv39_i,
    input  logic                  caps_pd8_i,
    output logic                  ar_valid_o,
    output logic [`CDW_PLEN-1:0]  ar_addr_o,
    output logic [7:0]            ar_len_o,
    input  logic                  ar_ready_i,
    input  logic                  r_valid_i,
    input  logic [`CDW_DW_W-1:0]  r_data_i,
    input  logic [1:0]            r_resp_i,
    input  logic                  r_last_i,
    output logic                  r_ready_o,
    output logic                  update_dc_o,
    output logic [`CDW_DID_W-1:0] up_did_o,
    output cdw_pkg::dc_base_t     up_dc_o,
    output logic                  cdw_error_o,
    output cdw_pkg::cause_t       cause_o,
    output logic                  active_o
);
    import cdw_pkg::*;

    logic                  start;
    logic [`CDW_PLEN-1:0]  root_ptr;
    walk_lvl_t             root_lvl;
    logic [`CDW_DID_W-1:0] did;
    logic                  beat_en;
    logic [1:0]            beat_idx;
    logic                  dc_clear;
    logic                  dc_invalid;
    logic                  dc_misconf;

    cdw_trigger u_trigger (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .init_i      (init_i),
        .req_did_i   (req_did_i),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .start_o     (start),
        .root_ptr_o  (root_ptr),
        .root_lvl_o  (root_lvl),
        .did_o       (did)
    );

    cdw_walker u_walker (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .root_ptr_i   (root_ptr),
        .root_lvl_i   (root_lvl),
        .did_i        (did),
        .ar_ready_i   (ar_ready_i),
        .r_valid_i    (r_valid_i),
        .r_data_i     (r_data_i),
        .r_resp_i     (r_resp_i),
        .r_last_i     (r_last_i),
        .dc_invalid_i (dc_invalid),
        .dc_misconf_i (dc_misconf),
        .ar_valid_o   (ar_valid_o),
        .ar_addr_o    (ar_addr_o),
        .ar_len_o     (ar_len_o),
        .r_ready_o    (r_ready_o),
        .beat_en_o    (beat_en),
        .beat_idx_o   (beat_idx),
        .dc_clear_o   (dc_clear),
        .active_o     (active_o),
        .update_dc_o  (update_dc_o),
        .up_did_o     (up_did_o),
        .cdw_error_o  (cdw_error_o),
        .cause_o      (cause_o)
    );

    dc_checker u_checker (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .clear_i       (dc_clear),
        .beat_en_i     (beat_en),
        .beat_idx_i    (beat_idx),
        .r_data_i      (r_data_i),
        .caps_ats_i    (caps_ats_i),
        .caps_sv39x4_i (caps_sv39x4_i),
        .caps_sv39_i   (caps_sv39_i),
        .caps_pd8_i    (caps_pd8_i),
        .dc_invalid_o  (dc_invalid),
        .dc_misconf_o  (dc_misconf),
        .up_dc_o       (up_dc_o)
    );

endmodule

/* design/dc_checker.sv */
/*
 * Device context store and checker. Keeps each leaf doubleword as it
 * arrives and flags it, in the same cycle, as invalid or misconfigured.
 */
`timescale 1ns/1ps
`include "cdw_consts.svh"

module dc_checker (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 clear_i,
    input  logic                 beat_en_i,
    input  logic [1:0]           beat_idx_i,
    input  logic [`CDW_DW_W-1:0] r_data_i,
    input  logic                 caps_ats_i,
    input  logic                 caps_sv39x4_i,
    input  logic                 caps_sv39_i,
    input  logic                 caps_pd8_i,
    output logic                 dc_invalid_o,
    output logic                 dc_misconf_o,
    output cdw_pkg::dc_base_t    up_dc_o
);
    import cdw_pkg::*;

    localparam logic [3:0] MODE_BARE = 4'd0;
    localparam logic [3:0] MODE_SV39 = 4'd8;
    localparam logic [3:0] MODE_PD8  = 4'd1;

    dc_base_t    dc_q;
    dc_tc_t      tc_in;
    dc_iohgatp_t gatp_in;
    dc_ta_t      ta_in;
    dc_fsc_t     fsc_in;

    logic tc_bad;
    logic gatp_bad;
    logic ta_bad;
    logic fsc_bad;

    assign tc_in   = dc_tc_t'(r_data_i);
    assign gatp_in = dc_iohgatp_t'(r_data_i);
    assign ta_in   = dc_ta_t'(r_data_i);
    assign fsc_in  = dc_fsc_t'(r_data_i);

    assign tc_bad = (|tc_in.reserved) ||
                    (tc_in.en_ats && !caps_ats_i) ||
                    ((tc_in.t2gpa || tc_in.en_pri) && !tc_in.en_ats);

    // Only sv39x4 is supported for the second stage
    assign gatp_bad = !(gatp_in.mode inside {MODE_BARE, MODE_SV39}) ||
                      ((gatp_in.mode == MODE_SV39) && !caps_sv39x4_i) ||
                      ((gatp_in.mode != MODE_BARE) && (|gatp_in.ppn[1:0])) ||
                      (dc_q.tc.t2gpa && (gatp_in.mode == MODE_BARE));

    assign ta_bad = (|ta_in.reserved_1) || (|ta_in.reserved_2);

    // fsc is read as a process directory or a page table, depending on pdtv
    always_comb begin
        if (dc_q.tc.pdtv) begin
            fsc_bad = !(fsc_in.mode inside {MODE_BARE, MODE_PD8}) ||
                      ((fsc_in.mode == MODE_PD8) && !caps_pd8_i);
        end else begin
            fsc_bad = !(fsc_in.mode inside {MODE_BARE, MODE_SV39}) ||
                      ((fsc_in.mode == MODE_SV39) && !caps_sv39_i);
        end
        fsc_bad = fsc_bad || (|fsc_in.reserved);
    end

    always_comb begin
        dc_invalid_o = 1'b0;
        dc_misconf_o = 1'b0;
        case (beat_idx_i)
            2'd0: begin
                dc_invalid_o = !tc_in.v;
                dc_misconf_o = tc_bad;
            end
            2'd1: dc_misconf_o = gatp_bad;
            2'd2: dc_misconf_o = ta_bad;
            default: dc_misconf_o = fsc_bad;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            dc_q <= '0;
        end else if (beat_en_i) begin
            case (beat_idx_i)
                2'd0: dc_q.tc <= tc_in;
                2'd1: dc_q.iohgatp <= gatp_in;
                2'd2: dc_q.ta <= ta_in;
                default: dc_q.fsc <= fsc_in;
            endcase
        end
    end

    assign up_dc_o = dc_q;

    a_idx_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        beat_en_i |-> !$isunknown(beat_idx_i));

endmodule

/* design/cdw_walker.sv */
/*
 * Walk state machine. Issues one read per directory level, follows
 * non-leaf entries, loads the leaf context as a four-beat burst and
 * drains the rest of a burst when a fault is found part way through.
 */
`timescale 1ns/1ps
`include "cdw_consts.svh"

module cdw_walker (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  start_i,
    input  logic [`CDW_PLEN-1:0]  root_ptr_i,
    input  cdw_pkg::walk_lvl_t    root_lvl_i,
    input  logic [`CDW_DID_W-1:0] did_i,
    input  logic                  ar_ready_i,
    input  logic                  r_valid_i,
    input  logic [`CDW_DW_W-1:0]  r_data_i,
    input  logic [1:0]            r_resp_i,
    input  logic                  r_last_i,
    input  logic                  dc_invalid_i,
    input  logic                  dc_misconf_i,
    output logic                  ar_valid_o,
    output logic [`CDW_PLEN-1:0]  ar_addr_o,
    output logic [7:0]            ar_len_o,
    output logic                  r_ready_o,
    output logic                  beat_en_o,
    output logic [1:0]            beat_idx_o,
    output logic                  dc_clear_o,
    output logic                  active_o,
    output logic                  update_dc_o,
    output logic [`CDW_DID_W-1:0] up_did_o,
    output logic                  cdw_error_o,
    output cdw_pkg::cause_t       cause_o
);
    import cdw_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [2:0] LAST_CNT  = 3'(`CDW_DC_BEATS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_NON_LEAF,
        S_LEAF,
        S_ERROR
    } state_t;

    state_t                state_q, state_d;
    walk_lvl_t             lvl_q, lvl_d;
    logic [`CDW_PLEN-1:0]  ptr_q, ptr_d;
    logic [`CDW_DID_W-1:0] did_q;
    logic [2:0]            cnt_q, cnt_d;
    cause_t                cause_q, cause_d;
    logic                  wait_rlast_q, wait_rlast_d;

    nl_entry_t nl;
    logic      beat_acc;
    logic      resp_err;
    logic      fail;
    cause_t    fail_cause;

    assign nl       = nl_entry_t'(r_data_i);
    assign beat_acc = r_valid_i && r_ready_o;
    assign resp_err = (r_resp_i != RESP_OKAY);

    assign active_o   = (state_q != S_IDLE);
    assign ar_valid_o = (state_q == S_ADDR);
    assign ar_addr_o  = ptr_q;
    assign ar_len_o   = (lvl_q == LVL1) ? 8'(`CDW_DC_BEATS - 1) : 8'd0;
    assign beat_idx_o = cnt_q[1:0];
    assign up_did_o   = did_q;
    assign cause_o    = cause_q;

    // Ready while a beat is expected, and while draining after a fault
    assign r_ready_o = (state_q == S_NON_LEAF) ||
                       ((state_q == S_LEAF) && (cnt_q != LAST_CNT)) ||
                       ((state_q == S_ERROR) && wait_rlast_q);

    always_comb begin
        state_d      = state_q;
        lvl_d        = lvl_q;
        ptr_d        = ptr_q;
        cnt_d        = cnt_q;
        cause_d      = cause_q;
        wait_rlast_d = wait_rlast_q;
        fail         = 1'b0;
        fail_cause   = `CDW_CAUSE_DDT_CORRUPT;
        beat_en_o    = 1'b0;
        dc_clear_o   = 1'b0;
        update_dc_o  = 1'b0;
        cdw_error_o  = 1'b0;

        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d      = S_ADDR;
                    lvl_d        = root_lvl_i;
                    ptr_d        = root_ptr_i;
                    cnt_d        = '0;
                    wait_rlast_d = 1'b0;
                    dc_clear_o   = 1'b1;
                end
            end
            S_ADDR: begin
                if (ar_ready_i) begin
                    state_d = (lvl_q == LVL1) ? S_LEAF : S_NON_LEAF;
                end
            end
            S_NON_LEAF: begin
                if (beat_acc) begin
                    if (resp_err) begin
                        fail = 1'b1;
                    end else if (!nl.v) begin
                        fail       = 1'b1;
                        fail_cause = `CDW_CAUSE_DDT_INVALID;
                    end else if ((|nl.reserved_1) || (|nl.reserved_2)) begin
                        fail       = 1'b1;
                        fail_cause = `CDW_CAUSE_DDT_MISCONF;
                    end else begin
                        // Descend one level
                        state_d = S_ADDR;
                        if (lvl_q == LVL3) begin
                            lvl_d = LVL2;
                            ptr_d = {nl.ppn, did_q[15:7], 3'b000};
                        end else begin
                            lvl_d = LVL1;
                            ptr_d = {nl.ppn, did_q[6:0], 5'b00000};
                        end
                    end
                end
            end
            S_LEAF: begin
                if (cnt_q == LAST_CNT) begin
                    update_dc_o = 1'b1;
                    state_d     = S_IDLE;
                end else if (beat_acc) begin
                    if (resp_err) begin
                        fail = 1'b1;
                    end else begin
                        beat_en_o = 1'b1;
                        cnt_d     = cnt_q + 3'd1;
                        if (dc_invalid_i) begin
                            fail       = 1'b1;
                            fail_cause = `CDW_CAUSE_DDT_INVALID;
                        end else if (dc_misconf_i) begin
                            fail       = 1'b1;
                            fail_cause = `CDW_CAUSE_DDT_MISCONF;
                        end
                    end
                end
            end
            S_ERROR: begin
                if (!wait_rlast_q || (beat_acc && r_last_i)) begin
                    cdw_error_o = 1'b1;
                    state_d     = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase

        // Any fault waits for the end of the burst before reporting
        if (fail) begin
            state_d      = S_ERROR;
            cause_d      = fail_cause;
            wait_rlast_d = !r_last_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= S_IDLE;
            lvl_q        <= LVL1;
            cnt_q        <= '0;
            cause_q      <= '0;
            wait_rlast_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            lvl_q        <= lvl_d;
            cnt_q        <= cnt_d;
            cause_q      <= cause_d;
            wait_rlast_q <= wait_rlast_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ptr_q <= ptr_d;
        if (dc_clear_o) begin
            did_q <= did_i;
        end
    end

    a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    a_one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_dc_o && cdw_error_o));

endmodule

/* design/cdw_trigger.sv */
/*
 * Walk trigger. Detects a rising edge of the context cache miss level
 * and forms the first directory pointer and level from ddtp and the id.
 */
`timescale 1ns/1ps
`include "cdw_consts.svh"

module cdw_trigger (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  init_i,
    input  logic [`CDW_DID_W-1:0] req_did_i,
    input  logic [`CDW_PPN_W-1:0] ddtp_ppn_i,
    input  logic [3:0]            ddtp_mode_i,
    output logic                  start_o,
    output logic [`CDW_PLEN-1:0]  root_ptr_o,
    output cdw_pkg::walk_lvl_t    root_lvl_o,
    output logic [`CDW_DID_W-1:0] did_o
);
    import cdw_pkg::*;

    logic init_q;
    logic mode_walk;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q <= 1'b0;
        end else begin
            init_q <= init_i;
        end
    end

    // Off and bare modes never walk
    assign mode_walk = (ddtp_mode_i == `CDW_MODE_1LVL) ||
                       (ddtp_mode_i == `CDW_MODE_2LVL) ||
                       (ddtp_mode_i == `CDW_MODE_3LVL);

    assign start_o = init_i && !init_q && mode_walk;
    assign did_o   = req_did_i;

    // Root index slice depends on how many levels the table has
    always_comb begin
        case (ddtp_mode_i)
            `CDW_MODE_3LVL: begin
                root_ptr_o = {ddtp_ppn_i, 1'b0, req_did_i[23:16], 3'b000};
                root_lvl_o = LVL3;
            end
            `CDW_MODE_2LVL: begin
                root_ptr_o = {ddtp_ppn_i, req_did_i[15:7], 3'b000};
                root_lvl_o = LVL2;
            end
            default: begin
                // Leaf table, 32-byte contexts
                root_ptr_o = {ddtp_ppn_i, req_did_i[6:0], 5'b00000};
                root_lvl_o = LVL1;
            end
        endcase
    end

endmodule

/* design/cdw_pkg.sv */
/*
 * Types of the device-context walker: directory entries, the four
 * context doublewords, walk levels and cause codes.
 */
`include "cdw_consts.svh"

package cdw_pkg;

    // Non-leaf device directory entry
    typedef struct packed {
        logic [9:0]            reserved_2;
        logic [`CDW_PPN_W-1:0] ppn;
        logic [8:0]            reserved_1;
        logic                  v;
    } nl_entry_t;

    // Translation control
    typedef struct packed {
        logic [31:0] reserved;
        // dpe, sade, gade, sbe, sxl and friends, not checked here
        logic [25:0] ctl;
        logic        pdtv;
        logic        prpr;
        logic        t2gpa;
        logic        en_pri;
        logic        en_ats;
        logic        v;
    } dc_tc_t;

    // Second-stage translation root
    typedef struct packed {
        logic [3:0]            mode;
        logic [15:0]           gscid;
        logic [`CDW_PPN_W-1:0] ppn;
    } dc_iohgatp_t;

    // Translation attributes
    typedef struct packed {
        logic [31:0] reserved_2;
        logic [19:0] pscid;
        logic [11:0] reserved_1;
    } dc_ta_t;

    // First-stage context, either a page table or a process directory
    typedef struct packed {
        logic [3:0]            mode;
        logic [15:0]           reserved;
        logic [`CDW_PPN_W-1:0] ppn;
    } dc_fsc_t;

    // Whole base-format context, tc in the low doubleword
    typedef struct packed {
        dc_fsc_t     fsc;
        dc_ta_t      ta;
        dc_iohgatp_t iohgatp;
        dc_tc_t      tc;
    } dc_base_t;

    // Directory levels still to be walked
    typedef enum logic [1:0] {
        LVL1 = 2'd1,
        LVL2 = 2'd2,
        LVL3 = 2'd3
    } walk_lvl_t;

    typedef logic [`CDW_CAUSE_W-1:0] cause_t;

endpackage

/* include/cdw_consts.svh */
/*
 * Widths, beat counts, ddtp mode encodings and cause codes for the
 * device-context walker. Include this wherever one of these is needed.
 */
`ifndef CDW_CONSTS_SVH
`define CDW_CONSTS_SVH

// Address and data widths
`define CDW_PPN_W 44
`define CDW_PLEN 56
`define CDW_DW_W 64
`define CDW_DID_W 24

// Doublewords in a base-format device context
`define CDW_DC_BEATS 4

// ddtp.MODE values that start a walk
`define CDW_MODE_1LVL 4'd2
`define CDW_MODE_2LVL 4'd3
`define CDW_MODE_3LVL 4'd4

// Fault causes reported by the walker
`define CDW_CAUSE_W 12
`define CDW_CAUSE_DDT_INVALID 12'd258
`define CDW_CAUSE_DDT_MISCONF 12'd259
`define CDW_CAUSE_DDT_CORRUPT 12'd268

`endif
